// File: rtl/icache_defines.svh
// ======================================================================
// Widths and sizes shared by the instruction-cache line-fill path
// Include this header wherever an address, line or slot width is needed
// The include directory must be on the compile path
// ======================================================================

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Address and data widths
`define ICACHE_ADDR_W     32
`define ICACHE_HALF_W     128
`define ICACHE_LINE_W     256

// Address fields: half select, set index and tag
`define ICACHE_HALF_BIT   4
`define ICACHE_SET_LSB    5
`define ICACHE_LOG_SETS   6
`define ICACHE_TAG_LSB    11
`define ICACHE_SETS       (1 << `ICACHE_LOG_SETS)
`define ICACHE_TAG_W      (`ICACHE_ADDR_W - `ICACHE_TAG_LSB)

// Associativity
`define ICACHE_LOG_WAYS   2
`define ICACHE_WAYS       (1 << `ICACHE_LOG_WAYS)

// Outstanding fills and bus transaction ids
`define ICACHE_SLOTS      8
`define ICACHE_SLOT_W     $clog2(`ICACHE_SLOTS)
`define ICACHE_REQ_W      (`ICACHE_SLOT_W + 1)
`define ICACHE_TID_W      8

`endif

// File: rtl/icache_pkg.sv
// ======================================================================
// Types for the instruction-cache line-fill path
// Refer to them by scoped name, e.g. icache_pkg::tid_t
// ======================================================================

`include "icache_defines.svh"

package icache_pkg;

	// Request view of a transaction id
	// The low bits form the request number that indexes the vtag table
	typedef struct packed {
		logic [`ICACHE_TID_W-`ICACHE_REQ_W-1:0] unused;
		logic [`ICACHE_REQ_W-1:0]               num;
	} tid_req_t;

	// Slot view of the same id, a fill slot and the half of the line
	typedef struct packed {
		logic [`ICACHE_TID_W-`ICACHE_REQ_W-1:0] unused;
		logic [`ICACHE_SLOT_W-1:0]              slot;
		logic                                   half;
	} tid_slot_t;

	// One bus transaction id, decoded either way
	typedef union packed {
		tid_req_t  req;
		tid_slot_t slot;
	} tid_t;

endpackage

// File: rtl/way_lfsr.sv
// ======================================================================
// 17-bit maximal-length LFSR for random way replacement
// Steps once per cycle while advance is high
// The low bits of value pick the victim way
// ======================================================================

`timescale 1ns/1ps

module way_lfsr (
	input  logic        clk,
	input  logic        rst,
	input  logic        advance,
	output logic [16:0] value
);

	logic feedback;

	// Fibonacci form with taps at bits 17 and 14, counting from one
	assign feedback = value[16] ^ value[13];

	// Any nonzero seed works, the all-zero state would lock up
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			value <= 17'h00001;
		else if (advance)
			value <= {value[15:0], feedback};
	end

endmodule

// File: rtl/icache_fill_requester.sv
// ======================================================================
// Fill requester for the instruction cache
// Takes a miss, allocates the lowest free fill slot, records the
// virtual address and issues two half-line bus reads on the next two
// cycles. The ack processor frees the slot when the line is written
// ======================================================================

`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_fill_requester (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       miss,
	input  logic [`ICACHE_ADDR_W-1:0]  miss_vadr,
	input  logic [`ICACHE_ADDR_W-1:0]  miss_padr,
	input  logic                       slot_free,
	input  logic [`ICACHE_SLOT_W-1:0]  free_slot,
	input  logic [`ICACHE_REQ_W-1:0]   vtag_rd_num,
	output logic                       miss_ready,
	output logic                       req,
	output logic [`ICACHE_ADDR_W-1:0]  req_adr,
	output icache_pkg::tid_t           req_tid,
	output logic [`ICACHE_ADDR_W-1:0]  vtag_rd
);

	logic [`ICACHE_SLOTS-1:0]   busy;
	logic                       pending;
	logic [`ICACHE_SLOT_W-1:0]  pend_slot;
	logic [`ICACHE_ADDR_W-1:0]  pend_adr;
	logic [`ICACHE_SLOT_W-1:0]  alloc_slot;
	logic                       accept;
	logic [`ICACHE_ADDR_W-1:0]  line_base;
	logic [`ICACHE_ADDR_W-1:0]  vtag_tbl [0:(1 << `ICACHE_REQ_W)-1];

	// A second miss must wait for the upper-half request to go out
	assign miss_ready = ~pending & ~(&busy);
	assign accept     = miss & miss_ready;

	// Lowest half of the line, byte offset cleared
	assign line_base = {miss_padr[`ICACHE_ADDR_W-1:`ICACHE_SET_LSB], `ICACHE_SET_LSB'(0)};

	// Priority pick of the lowest free slot
	// The descending loop lets the lowest index win
	always_comb begin
		alloc_slot = '0;
		for (int i = `ICACHE_SLOTS - 1; i >= 0; i--) begin
			if (!busy[i])
				alloc_slot = i[`ICACHE_SLOT_W-1:0];
		end
	end

	// ==================================================================
	// Slot tracking and request strobe
	// ==================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy    <= '0;
			pending <= 1'b0;
			req     <= 1'b0;
		end else begin
			// The released slot and a new allocation never coincide
			if (slot_free)
				busy[free_slot] <= 1'b0;
			if (accept) begin
				busy[alloc_slot] <= 1'b1;
				pending          <= 1'b1;
				req              <= 1'b1;
			end else begin
				pending <= 1'b0;
				req     <= pending;
			end
		end
	end

	// Request address and id, lower half first then the held upper half
	always_ff @(posedge clk) begin
		if (accept) begin
			pend_slot                     <= alloc_slot;
			pend_adr                      <= line_base;
			pend_adr[`ICACHE_HALF_BIT]    <= 1'b1;
			req_adr                       <= line_base;
			req_tid.slot.unused           <= '0;
			req_tid.slot.slot             <= alloc_slot;
			req_tid.slot.half             <= 1'b0;
		end else if (pending) begin
			req_adr                       <= pend_adr;
			req_tid.slot.unused           <= '0;
			req_tid.slot.slot             <= pend_slot;
			req_tid.slot.half             <= 1'b1;
		end
	end

	// Virtual address table
	// Both request numbers of a slot hold the same address so either
	// response can fetch it
	always_ff @(posedge clk) begin
		if (accept) begin
			vtag_tbl[{alloc_slot, 1'b0}] <= miss_vadr;
			vtag_tbl[{alloc_slot, 1'b1}] <= miss_vadr;
		end
	end

	assign vtag_rd = vtag_tbl[vtag_rd_num];

endmodule

// File: rtl/icache_ack_processor.sv
// ======================================================================
// Ack processor for the instruction-cache fill path
// Collects half-line bus responses per fill slot in any order, then
// sends each complete line to the line store with a random way.
// One line leaves per cycle, lowest complete slot first
// ======================================================================

`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_ack_processor (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         resp_ack,
	input  logic [`ICACHE_ADDR_W-1:0]    resp_adr,
	input  icache_pkg::tid_t             resp_tid,
	input  logic [`ICACHE_HALF_W-1:0]    resp_dat,
	input  logic [`ICACHE_ADDR_W-1:0]    vtag_rd,
	input  logic [`ICACHE_LOG_WAYS-1:0]  way_rnd,
	output logic [`ICACHE_REQ_W-1:0]     vtag_rd_num,
	output logic                         line_wr,
	output logic [`ICACHE_SLOT_W-1:0]    line_slot,
	output logic [`ICACHE_ADDR_W-1:0]    line_vtag,
	output logic [`ICACHE_ADDR_W-1:0]    line_ptag,
	output logic [`ICACHE_LINE_W-1:0]    line_data,
	output logic [`ICACHE_LOG_WAYS-1:0]  line_way
);

	// Per-slot half valid bits, bit 0 lower half and bit 1 upper half
	logic [1:0]                   half_vld   [0:`ICACHE_SLOTS-1];

	// Staging lines
	logic [`ICACHE_ADDR_W-1:0]    stage_vtag [0:`ICACHE_SLOTS-1];
	logic [`ICACHE_ADDR_W-1:0]    stage_ptag [0:`ICACHE_SLOTS-1];
	logic [`ICACHE_LINE_W-1:0]    stage_data [0:`ICACHE_SLOTS-1];

	logic [`ICACHE_SLOT_W-1:0]    resp_slot;
	logic                         resp_half;
	logic [`ICACHE_ADDR_W-1:0]    resp_vtag;
	logic [`ICACHE_ADDR_W-1:0]    resp_ptag;
	logic                         done_found;
	logic [`ICACHE_SLOT_W-1:0]    done_slot;

	// The id is read as a request number for the vtag table and as a
	// slot number for the staging line
	assign vtag_rd_num = resp_tid.req.num;
	assign resp_slot   = resp_tid.slot.slot;

	// The address bit, not the id, places the data in the line
	assign resp_half = resp_adr[`ICACHE_HALF_BIT];

	// Tags are kept with the half bit cleared so both halves agree
	assign resp_vtag = {vtag_rd[`ICACHE_ADDR_W-1:`ICACHE_HALF_BIT+1], 1'b0,
		vtag_rd[`ICACHE_HALF_BIT-1:0]};
	assign resp_ptag = {resp_adr[`ICACHE_ADDR_W-1:`ICACHE_HALF_BIT+1], 1'b0,
		resp_adr[`ICACHE_HALF_BIT-1:0]};

	// ==================================================================
	// Completion scan
	// ==================================================================
	// Fixed priority, lowest slot wins. A slot cannot starve because
	// at most eight are outstanding and each is drained in one cycle
	always_comb begin
		done_found = 1'b0;
		done_slot  = '0;
		for (int i = `ICACHE_SLOTS - 1; i >= 0; i--) begin
			if (half_vld[i] == 2'b11) begin
				done_found = 1'b1;
				done_slot  = i[`ICACHE_SLOT_W-1:0];
			end
		end
	end

	// ==================================================================
	// Control state
	// ==================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			line_wr <= 1'b0;
			for (int i = 0; i < `ICACHE_SLOTS; i++)
				half_vld[i] <= 2'b00;
		end else begin
			line_wr <= done_found;
			if (resp_ack)
				half_vld[resp_slot][resp_half] <= 1'b1;
			// A complete slot gets no more responses until it is
			// reallocated, so the clear never races a set
			if (done_found)
				half_vld[done_slot] <= 2'b00;
		end
	end

	// Staging writes on every response
	always_ff @(posedge clk) begin
		if (resp_ack) begin
			stage_vtag[resp_slot] <= resp_vtag;
			stage_ptag[resp_slot] <= resp_ptag;
			if (resp_half)
				stage_data[resp_slot][`ICACHE_LINE_W-1:`ICACHE_HALF_W] <= resp_dat;
			else
				stage_data[resp_slot][`ICACHE_HALF_W-1:0] <= resp_dat;
		end
	end

	// Outgoing line, with the way taken from the LFSR in the same cycle
	always_ff @(posedge clk) begin
		if (done_found) begin
			line_slot <= done_slot;
			line_vtag <= stage_vtag[done_slot];
			line_ptag <= stage_ptag[done_slot];
			line_data <= stage_data[done_slot];
			line_way  <= way_rnd;
		end
	end

endmodule

// File: rtl/icache_line_store.sv
// ======================================================================
// Tag and data array of the instruction cache, 64 sets by 4 ways
// Indexed and tagged by virtual address. Fills arrive on line_wr and
// lookups answer one cycle later on hit_valid, hit and hit_data
// ======================================================================

`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_line_store (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         line_wr,
	input  logic [`ICACHE_ADDR_W-1:0]    line_vtag,
	input  logic [`ICACHE_ADDR_W-1:0]    line_ptag,
	input  logic [`ICACHE_LINE_W-1:0]    line_data,
	input  logic [`ICACHE_LOG_WAYS-1:0]  line_way,
	input  logic                         lookup,
	input  logic [`ICACHE_ADDR_W-1:0]    lookup_adr,
	output logic                         hit_valid,
	output logic                         hit,
	output logic [`ICACHE_LINE_W-1:0]    hit_data
);

	// ==================================================================
	// Arrays
	// ==================================================================
	logic [`ICACHE_WAYS-1:0]   valid    [0:`ICACHE_SETS-1];
	logic [`ICACHE_TAG_W-1:0]  vtag_arr [0:`ICACHE_SETS-1][0:`ICACHE_WAYS-1];
	logic [`ICACHE_LINE_W-1:0] data_arr [0:`ICACHE_SETS-1][0:`ICACHE_WAYS-1];

	logic [`ICACHE_LOG_SETS-1:0] wr_set;
	logic [`ICACHE_LOG_SETS-1:0] rd_set;
	logic [`ICACHE_TAG_W-1:0]    rd_tag;
	logic                        rd_hit;
	logic [`ICACHE_LINE_W-1:0]   rd_data;

	assign wr_set = line_vtag[`ICACHE_SET_LSB+`ICACHE_LOG_SETS-1:`ICACHE_SET_LSB];
	assign rd_set = lookup_adr[`ICACHE_SET_LSB+`ICACHE_LOG_SETS-1:`ICACHE_SET_LSB];
	assign rd_tag = lookup_adr[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];

	// Valid bits are the only array state cleared by reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int s = 0; s < `ICACHE_SETS; s++)
				valid[s] <= '0;
		end else if (line_wr) begin
			valid[wr_set][line_way] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (line_wr) begin
			vtag_arr[wr_set][line_way] <= line_vtag[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
			data_arr[wr_set][line_way] <= line_data;
		end
	end

	// ==================================================================
	// Lookup
	// ==================================================================
	// Compare all four ways of the set at once
	// Distinct fills never share a tag in a set, so at most one matches
	always_comb begin
		rd_hit  = 1'b0;
		rd_data = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (valid[rd_set][w] && vtag_arr[rd_set][w] == rd_tag) begin
				rd_hit  = 1'b1;
				rd_data = data_arr[rd_set][w];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hit_valid <= 1'b0;
			hit       <= 1'b0;
		end else begin
			hit_valid <= lookup;
			hit       <= lookup & rd_hit;
		end
	end

	// Line data is only meaningful with hit
	always_ff @(posedge clk) begin
		if (lookup)
			hit_data <= rd_data;
	end

endmodule

// File: rtl/icache_fill_top.sv
// ======================================================================
// Top level of the instruction-cache line-fill path
// Wires the fill requester, ack processor, replacement LFSR and line
// store together. The bus and lookup ports face the outside
// ======================================================================

`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_fill_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       miss,
	input  logic [`ICACHE_ADDR_W-1:0]  miss_vadr,
	input  logic [`ICACHE_ADDR_W-1:0]  miss_padr,
	input  logic                       resp_ack,
	input  logic [`ICACHE_ADDR_W-1:0]  resp_adr,
	input  icache_pkg::tid_t           resp_tid,
	input  logic [`ICACHE_HALF_W-1:0]  resp_dat,
	input  logic                       lookup,
	input  logic [`ICACHE_ADDR_W-1:0]  lookup_adr,
	output logic                       miss_ready,
	output logic                       req,
	output logic [`ICACHE_ADDR_W-1:0]  req_adr,
	output icache_pkg::tid_t           req_tid,
	output logic                       hit_valid,
	output logic                       hit,
	output logic [`ICACHE_LINE_W-1:0]  hit_data
);

	logic [`ICACHE_REQ_W-1:0]     vtag_rd_num;
	logic [`ICACHE_ADDR_W-1:0]    vtag_rd;
	logic                         line_wr;
	logic [`ICACHE_SLOT_W-1:0]    line_slot;
	logic [`ICACHE_ADDR_W-1:0]    line_vtag;
	logic [`ICACHE_ADDR_W-1:0]    line_ptag;
	logic [`ICACHE_LINE_W-1:0]    line_data;
	logic [`ICACHE_LOG_WAYS-1:0]  line_way;
	logic [16:0]                  lfsr_value;

	// The line write also frees the slot in the requester
	icache_fill_requester i_requester (
		.clk         (clk),
		.rst         (rst),
		.miss        (miss),
		.miss_vadr   (miss_vadr),
		.miss_padr   (miss_padr),
		.slot_free   (line_wr),
		.free_slot   (line_slot),
		.vtag_rd_num (vtag_rd_num),
		.miss_ready  (miss_ready),
		.req         (req),
		.req_adr     (req_adr),
		.req_tid     (req_tid),
		.vtag_rd     (vtag_rd)
	);

	icache_ack_processor i_ack_processor (
		.clk         (clk),
		.rst         (rst),
		.resp_ack    (resp_ack),
		.resp_adr    (resp_adr),
		.resp_tid    (resp_tid),
		.resp_dat    (resp_dat),
		.vtag_rd     (vtag_rd),
		.way_rnd     (lfsr_value[`ICACHE_LOG_WAYS-1:0]),
		.vtag_rd_num (vtag_rd_num),
		.line_wr     (line_wr),
		.line_slot   (line_slot),
		.line_vtag   (line_vtag),
		.line_ptag   (line_ptag),
		.line_data   (line_data),
		.line_way    (line_way)
	);

	// Free-running, so the way depends on when a line completes
	way_lfsr i_way_lfsr (
		.clk     (clk),
		.rst     (rst),
		.advance (1'b1),
		.value   (lfsr_value)
	);

	icache_line_store i_line_store (
		.clk        (clk),
		.rst        (rst),
		.line_wr    (line_wr),
		.line_vtag  (line_vtag),
		.line_ptag  (line_ptag),
		.line_data  (line_data),
		.line_way   (line_way),
		.lookup     (lookup),
		.lookup_adr (lookup_adr),
		.hit_valid  (hit_valid),
		.hit        (hit),
		.hit_data   (hit_data)
	);

endmodule

// File: verification/bus_responder.sv
// ======================================================================
// Bus memory model for the fill-path testbench
// Queues every read request and answers it after a random delay of
// 1 to 20 cycles, at most one response per cycle, so responses return
// out of order. Data is the request address repeated four times,
// inverted when the address selects the upper half of a line.
// While stall is high every queued read is held back
// ======================================================================

`timescale 1ns/1ps
`include "icache_defines.svh"

module bus_responder (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       stall,
	input  logic                       req,
	input  logic [`ICACHE_ADDR_W-1:0]  req_adr,
	input  icache_pkg::tid_t           req_tid,
	output logic                       resp_ack,
	output logic [`ICACHE_ADDR_W-1:0]  resp_adr,
	output icache_pkg::tid_t           resp_tid,
	output logic [`ICACHE_HALF_W-1:0]  resp_dat
);

	int                         seed;
	int                         cycle;
	int                         pick;
	logic                       stalled;

	// Outstanding reads and the cycle each one is due
	logic [`ICACHE_ADDR_W-1:0]  pend_adr [$];
	icache_pkg::tid_t           pend_tid [$];
	int                         pend_due [$];

	// Memory contents as a function of the read address
	function automatic logic [`ICACHE_HALF_W-1:0] mem_data(
		input logic [`ICACHE_ADDR_W-1:0] adr
	);
		logic [`ICACHE_HALF_W-1:0] d;
		d = {4{adr}};
		if (adr[`ICACHE_HALF_BIT])
			d = ~d;
		return d;
	endfunction

	initial begin
		seed     = 72;
		cycle    = 0;
		stalled  = 1'b0;
		resp_ack = 1'b0;
		resp_adr = '0;
		resp_tid = '0;
		resp_dat = '0;
		forever begin
			@(posedge clk);
			// The stall is taken at the edge like a registered input
			stalled = stall;
			// Everything else happens just after the edge, where the DUT outputs are settled
			#1;
			if (rst) begin
				pend_adr.delete();
				pend_tid.delete();
				pend_due.delete();
				resp_ack = 1'b0;
			end else begin
				cycle++;
				if (req) begin
					pend_adr.push_back(req_adr);
					pend_tid.push_back(req_tid);
					pend_due.push_back(cycle + 1 + int'({$random(seed)} % 20));
				end
				// The earliest due read goes out, the rest wait a cycle
				pick = -1;
				for (int i = 0; i < pend_due.size(); i++) begin
					if (pend_due[i] <= cycle && (pick < 0 || pend_due[i] < pend_due[pick]))
						pick = i;
				end
				if (pick >= 0 && !stalled) begin
					resp_ack = 1'b1;
					resp_adr = pend_adr[pick];
					resp_tid = pend_tid[pick];
					resp_dat = mem_data(pend_adr[pick]);
					pend_adr.delete(pick);
					pend_tid.delete(pick);
					pend_due.delete(pick);
				end else begin
					resp_ack = 1'b0;
				end
			end
		end
	end

endmodule

// File: verification/tb_icache_fill.sv
// ======================================================================
// Testbench for the instruction-cache line-fill path
// Walks a table of virtual and physical line addresses, issues misses,
// lets the bus model answer out of order and checks each line by
// lookup. Entries marked as no hit share a set with a filled line
// ======================================================================

`timescale 1ns/1ps
`include "icache_defines.svh"

module tb_icache_fill;

	localparam int N_ENTRIES     = 12;
	localparam int NINTH         = 9;
	localparam int READY_TIMEOUT = 200;
	localparam int HIT_TIMEOUT   = 8;
	localparam int FILL_TRIES    = 300;

	typedef struct packed {
		logic [`ICACHE_ADDR_W-1:0] vadr;
		logic [`ICACHE_ADDR_W-1:0] padr;
		logic                      expect_hit;
	} entry_t;

	logic                       clk = 1'b0;
	logic                       rst;
	logic                       miss;
	logic [`ICACHE_ADDR_W-1:0]  miss_vadr;
	logic [`ICACHE_ADDR_W-1:0]  miss_padr;
	logic                       resp_ack;
	logic [`ICACHE_ADDR_W-1:0]  resp_adr;
	icache_pkg::tid_t           resp_tid;
	logic [`ICACHE_HALF_W-1:0]  resp_dat;
	logic                       lookup;
	logic [`ICACHE_ADDR_W-1:0]  lookup_adr;
	logic                       miss_ready;
	logic                       req;
	logic [`ICACHE_ADDR_W-1:0]  req_adr;
	icache_pkg::tid_t           req_tid;
	logic                       hit_valid;
	logic                       hit;
	logic [`ICACHE_LINE_W-1:0]  hit_data;
	logic                       bus_stall;

	entry_t                     tbl [0:N_ENTRIES-1];

	always #50 clk = ~clk;

	icache_fill_top i_icache_fill_top (
		.clk        (clk),
		.rst        (rst),
		.miss       (miss),
		.miss_vadr  (miss_vadr),
		.miss_padr  (miss_padr),
		.resp_ack   (resp_ack),
		.resp_adr   (resp_adr),
		.resp_tid   (resp_tid),
		.resp_dat   (resp_dat),
		.lookup     (lookup),
		.lookup_adr (lookup_adr),
		.miss_ready (miss_ready),
		.req        (req),
		.req_adr    (req_adr),
		.req_tid    (req_tid),
		.hit_valid  (hit_valid),
		.hit        (hit),
		.hit_data   (hit_data)
	);

	bus_responder i_bus_responder (
		.clk      (clk),
		.rst      (rst),
		.stall    (bus_stall),
		.req      (req),
		.req_adr  (req_adr),
		.req_tid  (req_tid),
		.resp_ack (resp_ack),
		.resp_adr (resp_adr),
		.resp_tid (resp_tid),
		.resp_dat (resp_dat)
	);

	// ==================================================================
	// Error handling and checks
	// ==================================================================
	task automatic stop_on_error();
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [`ICACHE_LINE_W-1:0] actual,
		input logic [`ICACHE_LINE_W-1:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
			stop_on_error();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		stop_on_error();
	endtask

	// Bus address of one half of the line that holds padr
	function automatic logic [`ICACHE_ADDR_W-1:0] half_addr(
		input logic [`ICACHE_ADDR_W-1:0] padr, input logic upper
	);
		return (padr & ~32'h1f) | (upper ? 32'h10 : 32'h0);
	endfunction

	// The lower half of a line holds its own bus address four times and
	// the upper half holds the upper-half address four times inverted
	function automatic logic [`ICACHE_LINE_W-1:0] expected_line(
		input logic [`ICACHE_ADDR_W-1:0] padr
	);
		return {~{4{half_addr(padr, 1'b1)}}, {4{half_addr(padr, 1'b0)}}};
	endfunction

	task automatic set_entry(input int idx, input logic [`ICACHE_ADDR_W-1:0] vadr,
		input logic [`ICACHE_ADDR_W-1:0] padr, input logic expect_hit);
		tbl[idx].vadr       = vadr;
		tbl[idx].padr       = padr;
		tbl[idx].expect_hit = expect_hit;
	endtask

	// ==================================================================
	// Stimulus tasks, all entered 1 ns after a rising edge
	// ==================================================================
	// The miss stays asserted until miss_ready lets it through
	// A negative exp_slot accepts whichever slot the requester picks
	task automatic issue_miss(input logic [`ICACHE_ADDR_W-1:0] vadr,
		input logic [`ICACHE_ADDR_W-1:0] padr, input int exp_slot);
		int                        waited;
		logic [`ICACHE_SLOT_W-1:0] slot;
		waited    = 0;
		miss      = 1'b1;
		miss_vadr = vadr;
		miss_padr = padr;
		while (!miss_ready) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > READY_TIMEOUT)
				report_timeout("miss_ready to rise");
		end
		@(posedge clk);
		#1;
		miss = 1'b0;
		// Accepted at that edge, so ready drops for a cycle
		check_value("miss_ready", 256'(miss_ready), 256'(0));
		// Lower half of the line goes out first
		slot = req_tid.slot.slot;
		check_value("req", 256'(req), 256'(1));
		check_value("req_adr", 256'(req_adr), 256'(half_addr(padr, 1'b0)));
		check_value("req_tid", 256'(req_tid), 256'({slot, 1'b0}));
		if (exp_slot >= 0)
			check_value("req_tid slot", 256'(slot), 256'(exp_slot));
		// Upper half on the next cycle from the same slot
		@(posedge clk);
		#1;
		check_value("req", 256'(req), 256'(1));
		check_value("req_adr", 256'(req_adr), 256'(half_addr(padr, 1'b1)));
		check_value("req_tid", 256'(req_tid), 256'({slot, 1'b1}));
	endtask

	// With every slot busy a miss is ignored for as long as the bus
	// stays stalled, then the stall is lifted so a slot can drain
	task automatic present_blocked_miss(input logic [`ICACHE_ADDR_W-1:0] vadr,
		input logic [`ICACHE_ADDR_W-1:0] padr);
		miss      = 1'b1;
		miss_vadr = vadr;
		miss_padr = padr;
		repeat (4) begin
			check_value("miss_ready", 256'(miss_ready), 256'(0));
			@(posedge clk);
			#1;
		end
		bus_stall = 1'b0;
	endtask

	// One lookup, answered exactly one cycle later
	task automatic run_lookup(input logic [`ICACHE_ADDR_W-1:0] adr, output logic got_hit,
		output logic [`ICACHE_LINE_W-1:0] got_data);
		int waited;
		lookup     = 1'b1;
		lookup_adr = adr;
		@(posedge clk);
		#1;
		lookup = 1'b0;
		waited = 1;
		while (!hit_valid) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > HIT_TIMEOUT)
				report_timeout("hit_valid after a lookup");
		end
		check_value("hit_valid latency", 256'(waited), 256'(1));
		got_hit  = hit;
		got_data = hit_data;
	endtask

	// Repeats the lookup until the line has been filled
	task automatic wait_fill(input logic [`ICACHE_ADDR_W-1:0] vadr,
		output logic [`ICACHE_LINE_W-1:0] data);
		int   tries;
		logic got_hit;
		tries   = 0;
		got_hit = 1'b0;
		while (!got_hit) begin
			run_lookup(vadr, got_hit, data);
			tries++;
			if (!got_hit && tries > FILL_TRIES)
				report_timeout($sformatf("the line fill of address 0x%h", vadr));
		end
	endtask

	// ==================================================================
	// Main sequence
	// ==================================================================
	initial begin
		logic                      got_hit;
		logic [`ICACHE_LINE_W-1:0] got_data;

		// Sets 1 to 8, 15 and 31; the last two entries reuse sets 3 and 31 with new tags
		set_entry(0,  32'h0001_0020, 32'h1234_5020, 1'b1);
		set_entry(1,  32'h0002_0040, 32'h0a00_0040, 1'b1);
		set_entry(2,  32'h0003_0060, 32'h0b10_0075, 1'b1);
		set_entry(3,  32'h0004_0094, 32'h0c20_0480, 1'b1);
		set_entry(4,  32'h0005_00a0, 32'h0d30_05a0, 1'b1);
		set_entry(5,  32'h0006_00c8, 32'h0e40_06d8, 1'b1);
		set_entry(6,  32'h0007_00e0, 32'h0f50_07e0, 1'b1);
		set_entry(7,  32'h0008_0100, 32'h8000_0100, 1'b1);
		set_entry(8,  32'h0009_01f0, 32'h9abc_def0, 1'b1);
		set_entry(9,  32'h7fff_fbe0, 32'hffff_ffe0, 1'b1);
		set_entry(10, 32'h0013_0060, 32'h0000_0000, 1'b0);
		set_entry(11, 32'h7ffe_fbe0, 32'h0000_0000, 1'b0);

		rst        = 1'b1;
		miss       = 1'b0;
		miss_vadr  = '0;
		miss_padr  = '0;
		lookup     = 1'b0;
		lookup_adr = '0;
		bus_stall  = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;

		// Nothing is valid after reset
		for (int i = 0; i < N_ENTRIES; i++) begin
			run_lookup(tbl[i].vadr, got_hit, got_data);
			check_value("hit", 256'(got_hit), 256'(0));
		end

		// A single fill on its own, which takes the lowest slot
		issue_miss(tbl[0].vadr, tbl[0].padr, 0);
		wait_fill(tbl[0].vadr, got_data);
		check_value("hit_data", got_data, expected_line(tbl[0].padr));

		// The bus is stalled so eight back-to-back misses fill slots 0 to 7
		// and the ninth finds none free until the responses flow again
		bus_stall = 1'b1;
		for (int i = 1; i < N_ENTRIES; i++) begin
			if (tbl[i].expect_hit) begin
				if (i == NINTH) begin
					present_blocked_miss(tbl[i].vadr, tbl[i].padr);
					issue_miss(tbl[i].vadr, tbl[i].padr, -1);
				end else begin
					issue_miss(tbl[i].vadr, tbl[i].padr, i - 1);
				end
			end
		end

		// Every filled line hits with its own data, other tags miss
		for (int i = 0; i < N_ENTRIES; i++) begin
			if (tbl[i].expect_hit) begin
				wait_fill(tbl[i].vadr, got_data);
				check_value("hit_data", got_data, expected_line(tbl[i].padr));
			end else begin
				run_lookup(tbl[i].vadr, got_hit, got_data);
				check_value("hit", 256'(got_hit), 256'(0));
			end
		end

		$display("Test passed");
		$finish;
	end

endmodule

// File: icache_fill.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/way_lfsr.sv
rtl/icache_fill_requester.sv
rtl/icache_ack_processor.sv
rtl/icache_line_store.sv
rtl/icache_fill_top.sv
verification/bus_responder.sv
verification/tb_icache_fill.sv

// File: Makefile
# Verilator build and run of the instruction-cache fill testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_icache_fill
FILELIST  = icache_fill.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
